//--- Makefile
TOP := tb_stage_fetch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module stage_fetch -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f --Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Address split for 4 KB pages
    localparam int ADDR_BITS = 32;
    localparam int PAGE_BITS = 12;
    localparam int VPN_BITS  = ADDR_BITS - PAGE_BITS;

    // One cache line holds four instruction words
    localparam int LINE_BITS = 128;

    // Virtual and physical page numbers share one width
    typedef logic [VPN_BITS-1:0] vpn_t;

    // TLB entry write, valid for one cycle
    typedef struct packed {
        logic valid;
        vpn_t vpn;
        vpn_t ppn;
    } tlb_fill_t;

    // Line read request toward external memory
    typedef struct packed {
        logic                 read_en;
        logic [ADDR_BITS-1:0] addr;
    } mem_req_t;

    // Line returned with a single-cycle ready pulse
    typedef struct packed {
        logic                 ready;
        logic [LINE_BITS-1:0] data;
    } mem_resp_t;

endpackage

`default_nettype wire

//--- logic/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int CACHE_SETS = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           lookup,
    input  logic [fetch_pkg::ADDR_BITS-1:0] paddr,
    input  fetch_pkg::mem_resp_t           mem_resp,
    output logic [31:0]                    word,
    output logic                           busy,
    output fetch_pkg::mem_req_t            mem_req
);
    import fetch_pkg::*;

    localparam int WORD_BITS   = 32;
    localparam int OFFSET_BITS = $clog2(LINE_BITS / 8);
    localparam int INDEX_BITS  = $clog2(CACHE_SETS);
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    logic [LINE_BITS-1:0]   line_q [CACHE_SETS];
    logic [TAG_BITS-1:0]    tag_q [CACHE_SETS];
    logic [CACHE_SETS-1:0]  valid_q;

    logic                   fill_active;
    logic [ADDR_BITS-1:0]   fill_addr;
    logic [INDEX_BITS-1:0]  fill_index;
    logic [TAG_BITS-1:0]    fill_tag;
    logic                   fill_done;

    logic [INDEX_BITS-1:0]  index;
    logic [TAG_BITS-1:0]    tag;
    logic [OFFSET_BITS-3:0] word_sel;
    logic                   hit;
    logic                   start_fill;

    // Lookup address fields
    assign index    = paddr[OFFSET_BITS +: INDEX_BITS];
    assign tag      = paddr[ADDR_BITS-1 -: TAG_BITS];
    assign word_sel = paddr[OFFSET_BITS-1:2];

    assign hit  = lookup && valid_q[index] && (tag_q[index] == tag);
    assign word = line_q[index][word_sel * WORD_BITS +: WORD_BITS];

    // Busy from the miss cycle until the line has been written
    assign busy       = fill_active || (lookup && !hit);
    assign start_fill = lookup && !hit && !fill_active;
    assign fill_done  = fill_active && mem_resp.ready;

    // Fill target comes from the latched request address
    assign fill_index = fill_addr[OFFSET_BITS +: INDEX_BITS];
    assign fill_tag   = fill_addr[ADDR_BITS-1 -: TAG_BITS];

    assign mem_req.read_en = fill_active;
    assign mem_req.addr    = fill_addr;

    // Fill FSM and valid bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_active <= 1'b0;
            valid_q     <= '0;
        end else if (start_fill) begin
            fill_active <= 1'b1;
        end else if (fill_done) begin
            fill_active         <= 1'b0;
            valid_q[fill_index] <= 1'b1;
        end
    end

    // Request address, tags and line data
    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill_addr <= {paddr[ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(0)};
        end
        if (fill_done) begin
            line_q[fill_index] <= mem_resp.data;
            tag_q[fill_index]  <= fill_tag;
        end
    end

endmodule

`default_nettype wire

//--- logic/itlb.sv
`timescale 1ns/1ps
`default_nettype none

module itlb #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::vpn_t      vpn,
    input  fetch_pkg::tlb_fill_t fill,
    output fetch_pkg::vpn_t      ppn,
    output logic                 hit
);
    import fetch_pkg::*;

    localparam int PTR_BITS = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    vpn_t                   tag_q [TLB_ENTRIES];
    vpn_t                   ppn_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [PTR_BITS-1:0]    victim_q;

    // Parallel compare against every valid entry
    always_comb begin
        hit = 1'b0;
        ppn = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (valid_q[i] && tag_q[i] == vpn) begin
                hit = 1'b1;
                ppn = ppn_q[i];
            end
        end
        // Fill in flight answers at once, keeps a TLB miss to one stall cycle
        if (fill.valid && fill.vpn == vpn) begin
            hit = 1'b1;
            ppn = fill.ppn;
        end
    end

    // Valid bits and round-robin victim pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (fill.valid) begin
            valid_q[victim_q] <= 1'b1;
            if (victim_q == PTR_BITS'(TLB_ENTRIES - 1)) begin
                victim_q <= '0;
            end else begin
                victim_q <= victim_q + 1'b1;
            end
        end
    end

    // Entry contents
    always_ff @(posedge clk) begin
        if (fill.valid) begin
            tag_q[victim_q] <= fill.vpn;
            ppn_q[victim_q] <= fill.ppn;
        end
    end

endmodule

`default_nettype wire

//--- logic/stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch #(
    parameter logic [fetch_pkg::ADDR_BITS-1:0] INIT_ADDR   = 'h200,
    parameter logic [fetch_pkg::ADDR_BITS-1:0] PAGE_OFFSET = 'h1000,
    parameter int                              TLB_ENTRIES = 4,
    parameter int                              CACHE_SETS  = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            branch_taken,
    input  logic [fetch_pkg::ADDR_BITS-1:0] new_pc,
    input  logic                            pc_write_disable,
    input  fetch_pkg::mem_resp_t            mem_resp,
    output logic [fetch_pkg::ADDR_BITS-1:0] pc,
    output logic [31:0]                     instruction,
    output logic                            stall,
    output fetch_pkg::mem_req_t             mem_req
);
    import fetch_pkg::*;

    vpn_t                 tlb_ppn;
    logic                 tlb_hit;
    logic                 tlb_miss;
    tlb_fill_t            tlb_fill;
    logic [ADDR_BITS-1:0] paddr;
    logic                 cache_busy;

    assign tlb_miss = !tlb_hit;
    assign stall    = tlb_miss || cache_busy;

    // Physical address only used when the TLB hits
    assign paddr = {tlb_ppn, pc[PAGE_BITS-1:0]};

    // Freeze first, then redirect, then sequential advance
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= INIT_ADDR;
        end else if (!pc_write_disable) begin
            if (branch_taken) begin
                pc <= new_pc;
            end else if (!stall) begin
                pc <= pc + ADDR_BITS'(4);
            end
        end
    end

    itlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_itlb (
        .clk  (clk),
        .reset(reset),
        .vpn  (pc[ADDR_BITS-1:PAGE_BITS]),
        .fill (tlb_fill),
        .ppn  (tlb_ppn),
        .hit  (tlb_hit)
    );

    tlb_refill #(
        .PAGE_OFFSET(PAGE_OFFSET)
    ) u_refill (
        .clk  (clk),
        .reset(reset),
        .miss (tlb_miss),
        .vpn  (pc[ADDR_BITS-1:PAGE_BITS]),
        .fill (tlb_fill)
    );

    // A TLB miss never reaches the cache
    icache #(
        .CACHE_SETS(CACHE_SETS)
    ) u_icache (
        .clk     (clk),
        .reset   (reset),
        .lookup  (tlb_hit),
        .paddr   (paddr),
        .mem_resp(mem_resp),
        .word    (instruction),
        .busy    (cache_busy),
        .mem_req (mem_req)
    );

endmodule

`default_nettype wire

//--- logic/tlb_refill.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_refill #(
    parameter logic [fetch_pkg::ADDR_BITS-1:0] PAGE_OFFSET = 'h1000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 miss,
    input  fetch_pkg::vpn_t      vpn,
    output fetch_pkg::tlb_fill_t fill
);
    import fetch_pkg::*;

    // Page number part of the fixed OS mapping
    localparam vpn_t OFFSET_PN = PAGE_OFFSET[ADDR_BITS-1:PAGE_BITS];

    // The registered fill doubles as the pending flag, so one miss
    // yields exactly one fill pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill <= '0;
        end else if (miss && !fill.valid) begin
            fill.valid <= 1'b1;
            fill.vpn   <= vpn;
            fill.ppn   <= vpn + OFFSET_PN;
        end else begin
            fill.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- sim/stage_fetch_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch_asserts (
    input logic                            clk,
    input logic                            reset,
    input logic                            tlb_miss,
    input logic                            branch_taken,
    input logic [fetch_pkg::ADDR_BITS-1:0] pc,
    input fetch_pkg::mem_req_t             mem_req,
    input fetch_pkg::mem_resp_t            mem_resp
);

    // Request held with a fixed address until the line arrives
    addr_stable_a : assert property (
        @(posedge clk) disable iff (reset)
        mem_req.read_en && !mem_resp.ready |=> mem_req.read_en && $stable(mem_req.addr)
    ) else $error("line request dropped or moved before ready");

    // A TLB miss stalls the PC unless a redirect takes over
    miss_stalls_a : assert property (
        @(posedge clk) disable iff (reset)
        tlb_miss && !branch_taken |=> $stable(pc)
    ) else $error("PC advanced during a TLB miss");

    reset_quiet_a : assert property (
        @(posedge clk) reset |-> !mem_req.read_en
    ) else $error("read_en high during reset");

endmodule

bind stage_fetch stage_fetch_asserts u_asserts (
    .clk         (clk),
    .reset       (reset),
    .tlb_miss    (tlb_miss),
    .branch_taken(branch_taken),
    .pc          (pc),
    .mem_req     (mem_req),
    .mem_resp    (mem_resp)
);

`default_nettype wire

//--- sim/tb_stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stage_fetch;
    import fetch_pkg::*;

    localparam logic [31:0] INIT_ADDR    = 32'h0000_0200;
    localparam logic [31:0] PAGE_OFFSET  = 32'h0000_1000;
    localparam logic [31:0] WORD_MASK    = 32'hA5A5_0000;
    localparam int          RESET_CYCLES = 8;

    // Worst fetch is a TLB refill plus a line fill at the longest latency
    localparam int CYCLES_PER_FETCH = 12;
    localparam int FETCH_BUDGET     = 80;
    localparam int HOLD_BUDGET      = 32;
    localparam int TIMEOUT_CYCLES   =
        2 * (RESET_CYCLES + HOLD_BUDGET + FETCH_BUDGET * CYCLES_PER_FETCH);

    logic        clk = 1'b0;
    logic        reset;
    logic        branch_taken;
    logic [31:0] new_pc;
    logic        pc_write_disable;
    mem_resp_t   mem_resp = '0;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic        stall;
    mem_req_t    mem_req;

    integer      seed = 72742;
    int          cycle_count = 0;
    int          mem_wait = 0;
    logic        mem_pending = 1'b0;

    stage_fetch u_dut (
        .clk             (clk),
        .reset           (reset),
        .branch_taken    (branch_taken),
        .new_pc          (new_pc),
        .pc_write_disable(pc_write_disable),
        .mem_resp        (mem_resp),
        .pc              (pc),
        .instruction     (instruction),
        .stall           (stall),
        .mem_req         (mem_req)
    );

    always #2 clk = ~clk;

    // Word at physical address A reads as A xor mask
    function automatic logic [LINE_BITS-1:0] memory_line(input logic [31:0] addr);
        logic [LINE_BITS-1:0] line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = (addr + 32'(i * 4)) ^ WORD_MASK;
        end
        return line;
    endfunction

    // OS mapping puts every page PAGE_OFFSET higher
    function automatic logic [31:0] expected_instr(input logic [31:0] vaddr);
        return (vaddr + PAGE_OFFSET) ^ WORD_MASK;
    endfunction

    // Line memory with random latency of 1 to 5 cycles
    always @(negedge clk) begin
        mem_resp.ready = 1'b0;
        if (mem_pending) begin
            if (mem_wait == 1) begin
                mem_resp.ready = 1'b1;
                mem_resp.data  = memory_line(mem_req.addr);
                mem_pending    = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end else if (mem_req.read_en) begin
            mem_wait    = 1 + int'($unsigned($random(seed)) % 32'd5);
            mem_pending = 1'b1;
        end
    end

    task automatic end_in_failure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: fetch stage still busy after %0d cycles", TIMEOUT_CYCLES);
            end_in_failure();
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h",
                     test, what, expected, actual);
            end_in_failure();
        end
    endtask

    // Leaves the caller on the negedge where pc already holds target
    task automatic branch_to(input logic [31:0] target);
        branch_taken = 1'b1;
        new_pc       = target;
        @(negedge clk);
        branch_taken = 1'b0;
    endtask

    // Current cycle is examined first, returns on the last accepted fetch
    task automatic fetch_seq(input string test, input logic [31:0] start_pc, input int count);
        logic [31:0] exp_pc;
        int          got;
        exp_pc = start_pc;
        got    = 0;
        while (got < count) begin
            if (!stall) begin
                check_value(test, "pc", exp_pc, pc);
                check_value(test, "instruction", expected_instr(exp_pc), instruction);
                exp_pc = exp_pc + 32'd4;
                got++;
            end
            if (got < count) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic test_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("reset", "pc", INIT_ADDR, pc);
            check_value("reset", "read_en", 32'd0, 32'(mem_req.read_en));
        end
        reset = 1'b0;
        // First cycle out of reset is a TLB miss, no line request yet
        @(negedge clk);
        check_value("reset", "pc", INIT_ADDR, pc);
        check_value("reset", "read_en", 32'd0, 32'(mem_req.read_en));
    endtask

    task automatic test_sequential();
        // Crosses the line at 0x210
        fetch_seq("sequential", INIT_ADDR, 8);
        // Crosses the page at 0x1000
        branch_to(32'h0000_0FF4);
        fetch_seq("sequential", 32'h0000_0FF4, 8);
    endtask

    task automatic test_redirect();
        branch_to(32'h0000_5010);
        check_value("redirect", "pc", 32'h0000_5010, pc);
        // Page 5 not mapped yet
        check_value("redirect", "stall", 32'd1, 32'(stall));
        fetch_seq("redirect", 32'h0000_5010, 4);
    endtask

    task automatic test_freeze();
        logic [31:0] held;
        held             = pc;
        pc_write_disable = 1'b1;
        branch_taken     = 1'b1;
        new_pc           = 32'h0000_9000;
        repeat (6) begin
            @(negedge clk);
            check_value("freeze", "pc", held, pc);
        end
        branch_taken = 1'b0;
        while (stall) begin
            @(negedge clk);
        end
    endtask

    // Line at 0x5010 was filled by the redirect test
    task automatic test_reexecute();
        logic [31:0] exp_pc;
        pc_write_disable = 1'b0;
        branch_to(32'h0000_5010);
        for (int i = 0; i < 4; i++) begin
            exp_pc = 32'h0000_5010 + 32'(i * 4);
            check_value("reexecute", "stall", 32'd0, 32'(stall));
            check_value("reexecute", "read_en", 32'd0, 32'(mem_req.read_en));
            check_value("reexecute", "pc", exp_pc, pc);
            check_value("reexecute", "instruction", expected_instr(exp_pc), instruction);
            if (i < 3) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic test_random_latency();
        @(negedge clk);
        fetch_seq("random_latency", 32'h0000_5020, 40);
    endtask

    initial begin
        reset            = 1'b1;
        branch_taken     = 1'b0;
        new_pc           = '0;
        pc_write_disable = 1'b0;
        test_reset();
        test_sequential();
        test_redirect();
        test_freeze();
        test_reexecute();
        test_random_latency();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/fetch_pkg.sv
logic/itlb.sv
logic/tlb_refill.sv
logic/icache.sv
logic/stage_fetch.sv
sim/stage_fetch_asserts.sv
sim/tb_stage_fetch.sv
